// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  //////////////////////
  // Data path
  //////////////////////

  localparam int DATA_W = 32;  // Word width of the data memory

  //////////////////////
  // Pipeline operations
  //////////////////////

  typedef enum logic [3:0] {
    MEM_NONE = 4'd0,  // No access this cycle
    MEM_LB   = 4'd1,  // Load byte, sign-extended
    MEM_LBU  = 4'd2,  // Load byte, zero-extended
    MEM_LH   = 4'd3,  // Load halfword, sign-extended
    MEM_LHU  = 4'd4,  // Load halfword, zero-extended
    MEM_LW   = 4'd5,  // Load word
    MEM_SB   = 4'd6,  // Store byte
    MEM_SH   = 4'd7,  // Store halfword
    MEM_SW   = 4'd8   // Store word
  } mem_op_e;

  // Debug reader FSM
  typedef enum logic [1:0] {
    DBG_IDLE      = 2'd0,  // Waiting for req
    DBG_WAIT_GNT  = 2'd1,  // Read held on the bus until granted
    DBG_WAIT_DATA = 2'd2,  // Counting out the read latency
    DBG_ACK       = 2'd3   // Ack high until req falls
  } dbg_state_e;

endpackage

`default_nettype wire

// File: verilog/mem_bus_if.sv
`default_nettype none

// Word-access bus, one access per cycle when en and gnt are both high
interface mem_bus_if
  import mem_pkg::*;
#(
  parameter int ADDR_W = 8
) ();

  logic              en;     // Access request
  logic              we;     // 1 write, 0 read
  logic [3:0]        be;     // Byte lane enables for writes
  logic [ADDR_W-1:0] addr;   // Word address
  logic [DATA_W-1:0] wdata;  // Write data, already lane-aligned
  logic              gnt;    // Combinational grant from the memory
  logic [DATA_W-1:0] rdata;  // Read data, LAT cycles after acceptance

  // Access unit side
  modport requester (
    output en, we, be, addr, wdata,
    input  gnt, rdata
  );

  // Memory side
  modport memory (
    input  en, we, be, addr, wdata,
    output gnt, rdata
  );

endinterface

`default_nettype wire

// File: verilog/data_memory.sv
`default_nettype none

module data_memory
  import mem_pkg::*;
#(
  parameter int DEPTH   = 256,
  parameter int OUT_REG = 0
) (
  input  wire   i_clk,
  input  wire   i_rsta,
  input  wire   i_soft_reset,  // One-cycle pulse starts the sweep
  mem_bus_if.memory pipe,      // Pipeline bus, highest priority
  mem_bus_if.memory dbg,       // Debug bus, takes idle cycles only
  output logic  o_busy
);

  localparam int ADDR_W = $clog2(DEPTH);

  logic [DATA_W-1:0] ram [DEPTH];  // Block RAM array
  logic [DATA_W-1:0] ram_q;        // First read stage
  logic              own_q;        // Owner of ram_q, 1 = debug bus
  logic [DATA_W-1:0] dout;         // Read data after optional register
  logic              dout_own;     // Owner aligned with dout
  logic [ADDR_W-1:0] sweep_cnt;
  logic              busy;

  logic              acc_en;
  logic              acc_dbg;  // Accepted access came from debug bus
  logic              acc_we;
  logic [3:0]        acc_be;
  logic [ADDR_W-1:0] acc_addr;
  logic [DATA_W-1:0] acc_wdata;

  //////////////////////
  // Arbitration
  //////////////////////

  assign pipe.gnt = !busy;                // Sweep owns the RAM while it runs
  assign dbg.gnt  = !busy && !pipe.en;    // Debug only on a free cycle

  assign acc_dbg   = dbg.en && dbg.gnt;
  assign acc_en    = (pipe.en && pipe.gnt) || acc_dbg;
  assign acc_we    = acc_dbg ? dbg.we    : pipe.we;
  assign acc_be    = acc_dbg ? dbg.be    : pipe.be;
  assign acc_addr  = acc_dbg ? dbg.addr  : pipe.addr;
  assign acc_wdata = acc_dbg ? dbg.wdata : pipe.wdata;

  //////////////////////
  // Sweep
  //////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      busy      <= 1'b0;
      sweep_cnt <= '0;
    end else if (busy) begin
      sweep_cnt <= sweep_cnt + 1'b1;  // Wraps back to zero on the last word
      if (sweep_cnt == ADDR_W'(DEPTH - 1))
        busy <= 1'b0;
    end else if (i_soft_reset) begin
      busy <= 1'b1;  // Pulse ignored while a sweep is already running
    end
  end

  assign o_busy = busy;

  // RAM port, sweep writes take the place of bus accesses
  always_ff @(posedge i_clk) begin
    if (busy) begin
      ram[sweep_cnt] <= DATA_W'(sweep_cnt);  // Word n gets value n
    end else if (acc_en && acc_we) begin
      for (int i = 0; i < 4; i++)
        if (acc_be[i])
          ram[acc_addr][8*i +: 8] <= acc_wdata[8*i +: 8];
    end else if (acc_en) begin
      ram_q <= ram[acc_addr];  // No-change mode, writes keep ram_q
    end
  end

  // Owner bit follows the read data
  always_ff @(posedge i_clk) begin
    if (i_rsta)
      own_q <= 1'b0;
    else if (acc_en && !acc_we && !busy)
      own_q <= acc_dbg;
  end

  generate
    if (OUT_REG != 0) begin : g_out_reg
      logic [DATA_W-1:0] out_q;
      logic              own_q2;
      always_ff @(posedge i_clk) begin
        if (i_rsta) begin
          out_q  <= '0;
          own_q2 <= 1'b0;
        end else begin
          out_q  <= ram_q;  // Second cycle of latency
          own_q2 <= own_q;
        end
      end
      assign dout     = out_q;
      assign dout_own = own_q2;
    end else begin : g_no_reg
      assign dout     = ram_q;  // One-cycle read
      assign dout_own = own_q;
    end
  endgenerate

  assign pipe.rdata = dout_own ? '0 : dout;
  assign dbg.rdata  = dout_own ? dout : '0;

endmodule

`default_nettype wire

// File: verilog/load_store_unit.sv
`default_nettype none

module load_store_unit
  import mem_pkg::*;
#(
  parameter int DEPTH   = 256,
  parameter int OUT_REG = 0
) (
  input  wire               i_clk,
  input  wire               i_rsta,
  input  mem_op_e           i_op,
  input  wire  [31:0]       i_addr,   // Byte address from the pipeline
  input  wire  [DATA_W-1:0] i_wdata,  // Store data, low bits used for SB/SH
  mem_bus_if.requester      bus,
  output logic [DATA_W-1:0] o_load_data,
  output logic              o_load_valid,
  output logic              o_stall,
  output logic              o_misaligned
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int LAT    = 1 + OUT_REG;

  logic is_store;
  logic is_half;
  logic is_word;
  logic misalign;
  logic accepted;
  logic mis_q;

  logic [LAT-1:0]    pend_vld;        // Load in flight at each stage
  mem_op_e           pend_op  [LAT];  // Its operation
  logic [1:0]        pend_off [LAT];  // Its byte offset in the word
  logic [DATA_W-1:0] shifted;

  //////////////////////
  // Request decode
  //////////////////////

  always_comb begin
    is_store = (i_op == MEM_SB) || (i_op == MEM_SH) || (i_op == MEM_SW);
    is_half  = i_op inside {MEM_LH, MEM_LHU, MEM_SH};
    is_word  = i_op inside {MEM_LW, MEM_SW};
    misalign = (is_half && i_addr[0]) || (is_word && (i_addr[1:0] != 2'b00));
  end

  assign bus.en   = (i_op != MEM_NONE) && !misalign;  // Misaligned ops never issue
  assign bus.we   = is_store;
  assign bus.addr = i_addr[ADDR_W+1:2];               // Drop the byte offset

  // Lanes and replicated store data
  always_comb begin
    if (is_word) begin
      bus.be    = 4'b1111;
      bus.wdata = i_wdata;
    end else if (is_half) begin
      bus.be    = i_addr[1] ? 4'b1100 : 4'b0011;
      bus.wdata = {2{i_wdata[15:0]}};
    end else begin
      bus.be    = 4'b0001 << i_addr[1:0];
      bus.wdata = {4{i_wdata[7:0]}};
    end
  end

  assign o_stall  = !bus.gnt;  // Only a running sweep withholds the grant
  assign accepted = bus.en && bus.gnt;

  always_ff @(posedge i_clk) begin
    if (i_rsta)
      mis_q <= 1'b0;
    else
      mis_q <= (i_op != MEM_NONE) && misalign && bus.gnt;  // Pulse after acceptance
  end

  assign o_misaligned = mis_q;

  //////////////////////
  // Load return path
  //////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      pend_vld <= '0;
    end else begin
      pend_vld[0] <= accepted && !is_store;
      for (int i = 1; i < LAT; i++)
        pend_vld[i] <= pend_vld[i-1];
    end
  end

  always_ff @(posedge i_clk) begin
    pend_op[0]  <= i_op;
    pend_off[0] <= i_addr[1:0];
    for (int i = 1; i < LAT; i++) begin
      pend_op[i]  <= pend_op[i-1];
      pend_off[i] <= pend_off[i-1];
    end
  end

  assign o_load_valid = pend_vld[LAT-1];  // Lines up with bus.rdata
  assign shifted      = bus.rdata >> {pend_off[LAT-1], 3'b000};

  // Sign or zero extension by the load kind
  always_comb begin
    case (pend_op[LAT-1])
      MEM_LB:  o_load_data = {{(DATA_W-8){shifted[7]}}, shifted[7:0]};
      MEM_LBU: o_load_data = {{(DATA_W-8){1'b0}}, shifted[7:0]};
      MEM_LH:  o_load_data = {{(DATA_W-16){shifted[15]}}, shifted[15:0]};
      MEM_LHU: o_load_data = {{(DATA_W-16){1'b0}}, shifted[15:0]};
      default: o_load_data = bus.rdata;  // LW, offset is zero
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/debug_read_port.sv
`default_nettype none

module debug_read_port
  import mem_pkg::*;
#(
  parameter int DEPTH   = 256,
  parameter int OUT_REG = 0
) (
  input  wire               i_clk,
  input  wire               i_rsta,
  input  wire               i_dbg_req,   // Four-phase request
  input  wire  [$clog2(DEPTH)-1:0] i_dbg_addr,  // Held stable while req is high
  mem_bus_if.requester      bus,
  output logic [DATA_W-1:0] o_dbg_data,
  output logic              o_dbg_ack
);

  localparam int ADDR_W = $clog2(DEPTH);
  localparam int LAT    = 1 + OUT_REG;

  dbg_state_e state;
  logic [1:0] lat_cnt;  // Cycles since the read was granted

  // Read-only bus, word wide
  assign bus.en    = (state == DBG_WAIT_GNT);
  assign bus.we    = 1'b0;
  assign bus.be    = 4'b1111;
  assign bus.addr  = i_dbg_addr[ADDR_W-1:0];
  assign bus.wdata = '0;

  //////////////////////
  // Handshake FSM
  //////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      state   <= DBG_IDLE;
      lat_cnt <= '0;
    end else begin
      case (state)
        DBG_IDLE: begin
          if (i_dbg_req)
            state <= DBG_WAIT_GNT;
        end
        DBG_WAIT_GNT: begin
          lat_cnt <= '0;
          if (bus.gnt)
            state <= DBG_WAIT_DATA;  // Pipeline idle, read accepted
        end
        DBG_WAIT_DATA: begin
          if (lat_cnt == 2'(LAT - 1))
            state <= DBG_ACK;  // rdata valid this cycle
          else
            lat_cnt <= lat_cnt + 1'b1;
        end
        DBG_ACK: begin
          if (!i_dbg_req)
            state <= DBG_IDLE;  // Ack drops once req has fallen
        end
        default: state <= DBG_IDLE;
      endcase
    end
  end

  // Capture the word, then hold it through the ack phase
  always_ff @(posedge i_clk) begin
    if (state == DBG_WAIT_DATA && lat_cnt == 2'(LAT - 1))
      o_dbg_data <= bus.rdata;
  end

  assign o_dbg_ack = (state == DBG_ACK);

endmodule

`default_nettype wire

// File: verilog/mem_stage_top.sv
`default_nettype none

module mem_stage_top
  import mem_pkg::*;
#(
  parameter  int DEPTH   = 256,  // Words, power of two
  parameter  int OUT_REG = 0,    // 1 adds the output register
  localparam int ADDR_W  = $clog2(DEPTH)
) (
  input  wire               i_clk,
  input  wire               i_rsta,
  input  wire               i_soft_reset,
  input  mem_op_e           i_op,
  input  wire  [31:0]       i_addr,
  input  wire  [DATA_W-1:0] i_wdata,
  input  wire               i_dbg_req,
  input  wire  [ADDR_W-1:0] i_dbg_addr,
  output logic [DATA_W-1:0] o_load_data,
  output logic              o_load_valid,
  output logic              o_stall,
  output logic              o_misaligned,
  output logic              o_busy,
  output logic [DATA_W-1:0] o_dbg_data,
  output logic              o_dbg_ack
);

  //////////////////////
  // Buses
  //////////////////////

  mem_bus_if #(.ADDR_W(ADDR_W)) pipe_bus ();  // Load/store unit to memory
  mem_bus_if #(.ADDR_W(ADDR_W)) dbg_bus ();   // Debug reader to memory

  data_memory #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) data_memory_inst (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_soft_reset (i_soft_reset),
    .pipe         (pipe_bus.memory),
    .dbg          (dbg_bus.memory),
    .o_busy       (o_busy)
  );

  load_store_unit #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) load_store_unit_inst (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_op         (i_op),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .bus          (pipe_bus.requester),
    .o_load_data  (o_load_data),
    .o_load_valid (o_load_valid),
    .o_stall      (o_stall),
    .o_misaligned (o_misaligned)
  );

  debug_read_port #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) debug_read_port_inst (
    .i_clk      (i_clk),
    .i_rsta     (i_rsta),
    .i_dbg_req  (i_dbg_req),
    .i_dbg_addr (i_dbg_addr),
    .bus        (dbg_bus.requester),
    .o_dbg_data (o_dbg_data),
    .o_dbg_ack  (o_dbg_ack)
  );

endmodule

`default_nettype wire

// File: test/mem_stage_props.sv
`default_nettype none

module mem_stage_props #(
  parameter int DEPTH = 256
) (
  input wire i_clk,
  input wire i_rsta,
  input wire i_soft_reset,  // Sweep start pulse
  input wire i_dbg_req,
  input wire i_dbg_ack,
  input wire i_busy,      // Sweep running
  input wire i_pipe_gnt,  // Grant on the pipeline bus
  input wire i_dbg_gnt    // Grant on the debug bus
);

  localparam int RUN_W = $clog2(DEPTH) + 1;

  logic [RUN_W-1:0] busy_run;    // Length of the current sweep so far
  logic [RUN_W-1:0] sweep_left;  // Sweep cycles still to come after the pulse

  always_ff @(posedge i_clk) begin
    if (i_rsta || !i_busy)
      busy_run <= '0;
    else
      busy_run <= busy_run + 1'b1;
  end

  always_ff @(posedge i_clk) begin
    if (i_rsta)
      sweep_left <= '0;
    else if (sweep_left != '0)
      sweep_left <= sweep_left - 1'b1;
    else if (i_soft_reset)
      sweep_left <= RUN_W'(DEPTH);  // Window opens on the next cycle
  end

  //////////////////////
  // Debug handshake
  //////////////////////

  ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rsta)
    $rose(i_dbg_ack) |-> i_dbg_req)
    else $error("Debug ack rose with no request");

  ack_after_req_low: assert property (@(posedge i_clk) disable iff (i_rsta)
    $fell(i_dbg_ack) |-> !$past(i_dbg_req))
    else $error("Debug ack fell while the request was still high");

  //////////////////////
  // Sweep
  //////////////////////

  no_gnt_in_sweep: assert property (@(posedge i_clk) disable iff (i_rsta)
    (sweep_left != '0) |-> (!i_pipe_gnt && !i_dbg_gnt))
    else $error("A bus was granted during the sweep");

  sweep_length: assert property (@(posedge i_clk) disable iff (i_rsta)
    $fell(i_busy) |-> (busy_run == RUN_W'(DEPTH)))
    else $error("Sweep busy time differs from the memory depth");

endmodule

// Watches the memory grants and the debug port from the top level
bind mem_stage_top mem_stage_props #(
  .DEPTH (DEPTH)
) mem_stage_props_inst (
  .i_clk        (i_clk),
  .i_rsta       (i_rsta),
  .i_soft_reset (i_soft_reset),
  .i_dbg_req    (i_dbg_req),
  .i_dbg_ack    (o_dbg_ack),
  .i_busy       (o_busy),
  .i_pipe_gnt   (pipe_bus.gnt),
  .i_dbg_gnt    (dbg_bus.gnt)
);

`default_nettype wire

// File: test/tb_mem_stage.sv
`default_nettype none

module tb_mem_stage
  import mem_pkg::*;
();

  localparam int DEPTH          = 256;
  localparam int OUT_REG        = 1;
  localparam int LAT            = 1 + OUT_REG;  // Read latency in cycles
  localparam int TIMEOUT_CYCLES = 4000;         // Sweep plus about 300 ops and a margin

  logic        i_clk;
  logic        i_rsta;
  logic        i_soft_reset;
  mem_op_e     i_op;
  logic [31:0] i_addr;
  logic [31:0] i_wdata;
  logic        i_dbg_req;
  logic [7:0]  i_dbg_addr;
  logic [31:0] o_load_data;
  logic        o_load_valid;
  logic        o_stall;
  logic        o_misaligned;
  logic        o_busy;
  logic [31:0] o_dbg_data;
  logic        o_dbg_ack;

  logic [31:0] model [DEPTH];  // Reference copy of the RAM
  logic [31:0] exp_data [$];   // Expected load results in issue order
  int          exp_cycle [$];  // Cycle each result is due
  int          cycle = 0;
  int          errors = 0;
  int          loads_checked = 0;
  string       cur_test;

  mem_stage_top #(
    .DEPTH   (DEPTH),
    .OUT_REG (OUT_REG)
  ) mem_stage_top_inst (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_soft_reset (i_soft_reset),
    .i_op         (i_op),
    .i_addr       (i_addr),
    .i_wdata      (i_wdata),
    .i_dbg_req    (i_dbg_req),
    .i_dbg_addr   (i_dbg_addr),
    .o_load_data  (o_load_data),
    .o_load_valid (o_load_valid),
    .o_stall      (o_stall),
    .o_misaligned (o_misaligned),
    .o_busy       (o_busy),
    .o_dbg_data   (o_dbg_data),
    .o_dbg_ack    (o_dbg_ack)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  //////////////////////
  // Reference rules
  //////////////////////

  function automatic logic is_misaligned(input mem_op_e op, input logic [31:0] addr);
    case (op)
      MEM_LH, MEM_LHU, MEM_SH: return addr[0];
      MEM_LW, MEM_SW:          return addr[1:0] != 2'b00;
      default:                 return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] load_expect(input mem_op_e op, input logic [31:0] addr);
    logic [31:0] word;
    logic [7:0]  lane;
    logic [15:0] half;
    word = model[addr[9:2]];
    lane = word[{addr[1:0], 3'b000} +: 8];
    half = addr[1] ? word[31:16] : word[15:0];
    case (op)
      MEM_LB:  return {{24{lane[7]}}, lane};  // Sign from the byte
      MEM_LBU: return {24'h0, lane};
      MEM_LH:  return {{16{half[15]}}, half};
      MEM_LHU: return {16'h0, half};
      default: return word;
    endcase
  endfunction

  task automatic store_model(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
    case (op)
      MEM_SB:  model[addr[9:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
      MEM_SH:  model[addr[9:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
      default: model[addr[9:2]] = data;
    endcase
  endtask

  //////////////////////
  // Drivers
  //////////////////////

  // Present one op and return at the edge that accepts it
  task automatic issue_op(input mem_op_e op, input logic [31:0] addr,
                          input logic [31:0] data);
    i_op    <= op;
    i_addr  <= addr;
    i_wdata <= data;
    @(posedge i_clk);
    while (o_stall) @(posedge i_clk);  // Held through a sweep
    if (!is_misaligned(op, addr)) begin
      if (op inside {MEM_SB, MEM_SH, MEM_SW})
        store_model(op, addr, data);
      else if (op != MEM_NONE) begin
        exp_data.push_back(load_expect(op, addr));
        exp_cycle.push_back(cycle + LAT);
      end
    end
  endtask

  task automatic go_idle();
    i_op <= MEM_NONE;
    @(posedge i_clk);
  endtask

  task automatic drain_loads();
    go_idle();
    for (int i = 0; i < LAT + 4 && exp_data.size() != 0; i++)
      go_idle();
    if (exp_data.size() != 0) begin
      errors++;
      $display("%0d load results never arrived in %s", exp_data.size(), cur_test);
      exp_data.delete();
      exp_cycle.delete();
    end
  endtask

  // One four-phase read on the debug port
  task automatic dbg_read(input logic [7:0] a);
    i_dbg_addr <= a;
    i_dbg_req  <= 1'b1;
    @(posedge i_clk);
    while (!o_dbg_ack) @(posedge i_clk);
    if (o_dbg_data !== model[a]) begin
      errors++;
      $display("Fail %s: expected %h, actual %h", cur_test, model[a], o_dbg_data);
    end
    repeat (3) begin
      @(posedge i_clk);
      if (o_dbg_ack !== 1'b1) begin
        errors++;
        $display("Fail %s: expected ack 1 while req is high, actual %b",
                 cur_test, o_dbg_ack);
      end
    end
    i_dbg_req <= 1'b0;
    @(posedge i_clk);
    while (o_dbg_ack) @(posedge i_clk);  // Next req only after ack is low
  endtask

  task automatic expect_misaligned(input mem_op_e op, input logic [31:0] addr);
    issue_op(op, addr, $urandom());
    go_idle();
    if (o_misaligned !== 1'b1) begin
      errors++;
      $display("Fail %s: expected misaligned 1 for %s at %h, actual %b",
               cur_test, op.name(), addr, o_misaligned);
    end
    go_idle();
    if (o_misaligned !== 1'b0) begin
      errors++;
      $display("Fail %s: expected misaligned 0 one cycle later, actual %b",
               cur_test, o_misaligned);
    end
  endtask

  //////////////////////
  // Tests
  //////////////////////

  task automatic sweep_fill();
    int stall_cycles;
    cur_test     = "sweep";
    stall_cycles = 0;
    i_soft_reset <= 1'b1;
    @(posedge i_clk);
    i_soft_reset <= 1'b0;
    @(posedge i_clk);  // First stalled cycle
    while (o_stall) begin
      stall_cycles++;
      if (o_busy !== 1'b1) begin
        errors++;
        $display("Fail %s: expected busy 1 during stall, actual %b", cur_test, o_busy);
      end
      @(posedge i_clk);
    end
    if (stall_cycles != DEPTH) begin
      errors++;
      $display("Fail %s: expected %0d, actual %0d", cur_test, DEPTH, stall_cycles);
    end
    for (int n = 0; n < DEPTH; n++)
      model[8'(n)] = 32'(n);  // Word n holds n
    for (int n = 0; n < DEPTH; n++)
      issue_op(MEM_LW, 32'(n) << 2, 32'h0);
    drain_loads();
  endtask

  task automatic word_round_trip();
    logic [31:0] addrs [16];
    cur_test = "word";
    for (int i = 0; i < 16; i++) begin
      addrs[i] = {22'h0, 8'($urandom_range(255, 0)), 2'b00};
      issue_op(MEM_SW, addrs[i], $urandom());
    end
    for (int i = 0; i < 16; i++)
      issue_op(MEM_LW, addrs[i], 32'h0);  // Back to back
    drain_loads();
  endtask

  task automatic subword_access();
    logic [31:0] base;
    cur_test = "subword";
    for (int r = 0; r < 3; r++) begin
      base = {22'h0, 8'($urandom_range(255, 0)), 2'b00};
      for (int k = 0; k < 4; k++) begin
        issue_op(MEM_SB, base + 32'(k), $urandom());
        issue_op(MEM_LB, base + 32'(k), 32'h0);
        issue_op(MEM_LBU, base + 32'(k), 32'h0);
      end
      issue_op(MEM_LW, base, 32'h0);  // Other lanes untouched
      for (int k = 0; k < 4; k += 2) begin
        issue_op(MEM_SH, base + 32'(k), $urandom());
        issue_op(MEM_LH, base + 32'(k), 32'h0);
        issue_op(MEM_LHU, base + 32'(k), 32'h0);
      end
      issue_op(MEM_LW, base, 32'h0);
    end
    drain_loads();
  endtask

  task automatic misaligned_ops();
    logic [31:0] base;
    cur_test = "misaligned";
    base     = {22'h0, 8'($urandom_range(255, 0)), 2'b00};
    expect_misaligned(MEM_LH, base + 32'd1);
    expect_misaligned(MEM_LHU, base + 32'd3);
    expect_misaligned(MEM_SH, base + 32'd3);
    expect_misaligned(MEM_LW, base + 32'd2);
    expect_misaligned(MEM_SW, base + 32'd1);
    issue_op(MEM_LW, base, 32'h0);  // Word must be unchanged
    drain_loads();
  endtask

  task automatic debug_handshake();
    logic [7:0] daddr;
    cur_test = "debug";
    daddr    = 8'($urandom_range(255, 0));
    fork
      begin
        // Loads with a free cycle every third slot
        for (int i = 0; i < 30; i++) begin
          if (i % 3 == 2)
            go_idle();
          else
            issue_op(MEM_LW, {22'h0, 8'($urandom_range(255, 0)), 2'b00}, 32'h0);
        end
        go_idle();
      end
      begin
        dbg_read(daddr);
        dbg_read(daddr + 8'd1);
      end
    join
    drain_loads();
  endtask

  //////////////////////
  // Result checker and timeout
  //////////////////////

  always @(posedge i_clk) begin
    if (!i_rsta && o_load_valid === 1'b1) begin
      if (exp_data.size() == 0) begin
        errors++;
        $display("Load result with no load in flight in %s", cur_test);
      end else begin
        if (o_load_data !== exp_data[0]) begin
          errors++;
          $display("Fail %s: expected %h, actual %h", cur_test, exp_data[0], o_load_data);
        end
        if (cycle != exp_cycle[0]) begin
          errors++;
          $display("Fail %s latency: expected cycle %0d, actual cycle %0d",
                   cur_test, exp_cycle[0], cycle);
        end
        loads_checked++;
        void'(exp_data.pop_front());
        void'(exp_cycle.pop_front());
      end
    end
  end

  always @(posedge i_clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a test never finished", cycle);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(48));
    i_rsta       = 1'b1;
    i_soft_reset = 1'b0;
    i_op         = MEM_NONE;
    i_addr       = '0;
    i_wdata      = '0;
    i_dbg_req    = 1'b0;
    i_dbg_addr   = '0;
    cur_test     = "reset";
    repeat (4) @(posedge i_clk);
    i_rsta <= 1'b0;
    @(posedge i_clk);
    if ({o_busy, o_stall, o_load_valid, o_misaligned, o_dbg_ack} !== 5'b0) begin
      errors++;
      $display("Fail %s: expected %b, actual %b", cur_test, 5'b0,
               {o_busy, o_stall, o_load_valid, o_misaligned, o_dbg_ack});
    end
    sweep_fill();
    word_round_trip();
    subword_access();
    misaligned_ops();
    debug_handshake();
    $display("Loads checked: %0d, errors: %0d", loads_checked, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
verilog/mem_pkg.sv
verilog/mem_bus_if.sv
verilog/data_memory.sv
verilog/load_store_unit.sv
verilog/debug_read_port.sv
verilog/mem_stage_top.sv
test/mem_stage_props.sv
test/tb_mem_stage.sv

// File: Makefile
# Verilator build and run of the data-memory stage testbench

VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_mem_stage
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "Run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "SIMULATION PASSED" $(LOG); then \
	  echo "Run ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
